/* source/rob_pkg.sv */
`default_nettype none

package rob_pkg;

   // Core sizes
   localparam int RB_NUM_ENTS       = 8;
   localparam int NUM_GPRS          = 16;
   localparam int NUM_PRFS          = 32;
   localparam int NUM_SOURCES       = 2;
   localparam int NUM_COMPLETES     = 2;
   localparam int RR_QUIESCE_CYCLES = 5;

   localparam int RB_IDX_W = $clog2(RB_NUM_ENTS);
   localparam int GPR_W    = $clog2(NUM_GPRS);
   localparam int PRF_W    = $clog2(NUM_PRFS);
   localparam int RR_CNT_W = $clog2(RR_QUIESCE_CYCLES);

   // Wrap bit tells a full buffer from an empty one
   typedef struct packed {
      logic                wrap;
      logic [RB_IDX_W-1:0] idx;
   } t_rob_id;

   typedef logic [GPR_W-1:0] t_gpr_id;
   typedef logic [PRF_W-1:0] t_prf_id;

   typedef enum logic {
      OP_NONE,
      OP_REG
   } t_dst_type;

   typedef struct packed {
      t_dst_type dst_type;
      t_gpr_id   dst_gpr;
      logic      mispred;
   } t_uinstr;

   typedef struct packed {
      logic    valid;
      t_rob_id robid;
      logic    flush_needed;
   } t_rob_complete_pkt;

   typedef struct packed {
      logic    valid;
      t_prf_id prfid;
   } t_rat_reclaim_pkt;

   typedef struct packed {
      logic    valid;
      t_gpr_id gpr;
      t_prf_id prfid;
   } t_rat_restore_pkt;

   typedef enum logic {
      NUKE_BR_MISPRED,
      NUKE_EXCEPTION
   } t_nuke_type;

   typedef struct packed {
      logic       valid;
      t_nuke_type nuke_type;
   } t_nuke_pkt;

   // Static fields first, completion status last
   typedef struct packed {
      t_uinstr uinstr;
      t_prf_id pdst_old;
      logic    ready;
      logic    flush_needed;
   } t_rob_ent;

   typedef enum logic [1:0] {
      RR_IDLE,
      RR_QUIET,
      RR_WALK,
      RR_RESUME
   } t_rr_state;

   function automatic t_rob_id f_incr_robid(t_rob_id id);
      return t_rob_id'(id + 1'b1);
   endfunction

   function automatic t_rob_id f_decr_robid(t_rob_id id);
      return t_rob_id'(id - 1'b1);
   endfunction

   function automatic logic f_rob_full(t_rob_id head, t_rob_id tail);
      return (head.idx == tail.idx) && (head.wrap != tail.wrap);
   endfunction

   function automatic logic f_rob_empty(t_rob_id head, t_rob_id tail);
      return head == tail;
   endfunction

endpackage

`default_nettype wire

/* source/rob_entry.sv */
`timescale 1ns/1ns
`default_nettype none

module rob_entry (
   input  logic                       clk,
   input  logic                       reset,
   input  rob_pkg::t_rob_id           robid,
   input  logic                       alloc_en,
   input  rob_pkg::t_rob_ent          alloc_ent,
   input  rob_pkg::t_rob_complete_pkt complete [rob_pkg::NUM_COMPLETES-1:0],
   input  logic                       retire_en,
   input  logic                       flush_now,
   output logic                       valid,
   output rob_pkg::t_rob_ent          entry
);
   import rob_pkg::*;

   logic hit;
   logic hit_flush;

   // Any completion port may name this entry, wrap bit included
   always_comb begin
      hit       = 1'b0;
      hit_flush = 1'b0;
      for (int c = 0; c < NUM_COMPLETES; c++) begin
         if (complete[c].valid && (complete[c].robid == robid)) begin
            hit       = 1'b1;
            hit_flush = hit_flush | complete[c].flush_needed;
         end
      end
   end

   always_ff @(posedge clk) begin
      // Static fields stay put after a flush so the walk can read them
      if (alloc_en) begin
         entry.uinstr   <= alloc_ent.uinstr;
         entry.pdst_old <= alloc_ent.pdst_old;
      end
      // A flush drops every entry, the retiring head leaves through retire_en
      if (reset) begin
         valid              <= 1'b0;
         entry.ready        <= 1'b0;
         entry.flush_needed <= 1'b0;
      end else begin
         if (retire_en || flush_now) begin
            valid <= 1'b0;
         end else if (alloc_en) begin
            valid <= 1'b1;
         end
         if (alloc_en) begin
            entry.ready        <= 1'b0;
            entry.flush_needed <= 1'b0;
         end else if (hit) begin
            entry.ready        <= 1'b1;
            entry.flush_needed <= entry.flush_needed | hit_flush;
         end
      end
   end

endmodule

`default_nettype wire

/* source/rob.sv */
`timescale 1ns/1ns
`default_nettype none

module rob (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       alloc,
   input  rob_pkg::t_uinstr           alloc_uinstr,
   input  rob_pkg::t_prf_id           pdst_old,
   input  rob_pkg::t_rob_complete_pkt ex_complete,
   input  rob_pkg::t_rob_complete_pkt mm_complete,
   input  rob_pkg::t_gpr_id           src_gpr     [rob_pkg::NUM_SOURCES-1:0],
   output logic                       src_pending [rob_pkg::NUM_SOURCES-1:0],
   output rob_pkg::t_rob_id           src_robid   [rob_pkg::NUM_SOURCES-1:0],
   output logic                       rob_ready,
   output rob_pkg::t_rob_id           next_robid,
   output rob_pkg::t_rob_id           oldest_robid,
   output rob_pkg::t_uinstr           retire_uinstr,
   output rob_pkg::t_rat_reclaim_pkt  reclaim,
   output rob_pkg::t_rat_restore_pkt  restore,
   output rob_pkg::t_nuke_pkt         nuke,
   output logic                       resume_fetch
);
   import rob_pkg::*;

   t_rob_id                 head_id;
   t_rob_id                 tail_id;
   t_rob_ent                entries   [RB_NUM_ENTS-1:0];
   t_rob_id                 ent_robid [RB_NUM_ENTS-1:0];
   logic [RB_NUM_ENTS-1:0]  e_valid;
   logic [RB_NUM_ENTS-1:0]  e_alloc;
   logic [RB_NUM_ENTS-1:0]  e_retire;
   t_rob_ent                alloc_ent;
   t_rob_ent                head_entry;
   t_rob_complete_pkt       complete  [NUM_COMPLETES-1:0];
   logic                    rob_empty;
   logic                    rob_full;
   logic                    retire;
   logic                    flush_now;
   t_rr_state               rr_state;
   t_rr_state               rr_state_nxt;
   t_rob_id                 rr_robid;
   logic [RR_CNT_W-1:0]     rr_cnt;
   t_rob_ent                rr_entry;

   assign rob_empty    = f_rob_empty(head_id, tail_id);
   assign rob_full     = f_rob_full(head_id, tail_id);
   assign rob_ready    = !rob_full && (rr_state == RR_IDLE);
   assign next_robid   = tail_id;
   assign oldest_robid = head_id;

   // Head leaves one entry per retirement, a flush cuts the tail back
   always_ff @(posedge clk) begin
      if (reset) begin
         head_id <= '0;
         tail_id <= '0;
      end else begin
         if (retire) begin
            head_id <= f_incr_robid(head_id);
         end
         if (flush_now) begin
            tail_id <= f_incr_robid(head_id);
         end else if (alloc) begin
            tail_id <= f_incr_robid(tail_id);
         end
      end
   end

   assign head_entry = entries[head_id.idx];
   assign retire     = !rob_empty && head_entry.ready;
   assign flush_now  = retire && head_entry.flush_needed;
   assign e_retire   = retire ? (RB_NUM_ENTS'(1) << head_id.idx) : '0;
   assign e_alloc    = alloc ? (RB_NUM_ENTS'(1) << tail_id.idx) : '0;

   always_comb begin
      retire_uinstr   = head_entry.uinstr;
      reclaim.valid   = retire && (head_entry.uinstr.dst_type == OP_REG);
      reclaim.prfid   = head_entry.pdst_old;
      nuke.valid      = flush_now;
      nuke.nuke_type  = head_entry.uinstr.mispred ? NUKE_BR_MISPRED : NUKE_EXCEPTION;
   end

   always_comb begin
      alloc_ent              = '0;
      alloc_ent.uinstr       = alloc_uinstr;
      alloc_ent.pdst_old     = pdst_old;
   end

   assign complete[0] = ex_complete;
   assign complete[1] = mm_complete;

   for (genvar i = 0; i < RB_NUM_ENTS; i++) begin : g_ents
      // Slots below the head are one lap ahead of it
      assign ent_robid[i] = '{
         wrap: (RB_IDX_W'(i) >= head_id.idx) ? head_id.wrap : !head_id.wrap,
         idx:  RB_IDX_W'(i)
      };

      rob_entry i_rob_entry (
         .clk       (clk),
         .reset     (reset),
         .robid     (ent_robid[i]),
         .alloc_en  (e_alloc[i]),
         .alloc_ent (alloc_ent),
         .complete  (complete),
         .retire_en (e_retire[i]),
         .flush_now (flush_now),
         .valid     (e_valid[i]),
         .entry     (entries[i])
      );
   end

   for (genvar s = 0; s < NUM_SOURCES; s++) begin : g_src
      logic [RB_NUM_ENTS-1:0] match;
      logic [RB_IDX_W-1:0]    sel;

      for (genvar i = 0; i < RB_NUM_ENTS; i++) begin : g_match
         assign match[i] = e_valid[i] && (entries[i].uinstr.dst_type == OP_REG) &&
                           (entries[i].uinstr.dst_gpr == src_gpr[s]);
      end

      // Oldest slot first, so the last hit is the youngest writer
      always_comb begin
         logic [RB_IDX_W-1:0] idx;
         sel = '0;
         for (int k = RB_NUM_ENTS; k >= 1; k--) begin
            idx = tail_id.idx - RB_IDX_W'(k);
            if (match[idx]) begin
               sel = idx;
            end
         end
      end

      assign src_pending[s] = |match;
      assign src_robid[s]   = ent_robid[sel];
   end

   // Restore FSM, quiesce then walk the discarded entries youngest first
   always_comb begin
      rr_state_nxt = rr_state;
      case (rr_state)
         RR_IDLE:
            if (flush_now) rr_state_nxt = RR_QUIET;
         RR_QUIET:
            if (rr_cnt == '0) begin
               // Nothing younger than the flushing entry skips the walk
               rr_state_nxt = (rr_robid == f_decr_robid(head_id)) ? RR_RESUME : RR_WALK;
            end
         RR_WALK:
            if (rr_robid == head_id) rr_state_nxt = RR_RESUME;
         default:
            rr_state_nxt = RR_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rr_state <= RR_IDLE;
      end else begin
         rr_state <= rr_state_nxt;
      end
   end

   always_ff @(posedge clk) begin
      if (rr_state == RR_IDLE) begin
         rr_cnt <= RR_CNT_W'(RR_QUIESCE_CYCLES - 1);
      end else if (rr_state == RR_QUIET) begin
         rr_cnt <= rr_cnt - 1'b1;
      end
   end

   // An entry written in the flush cycle is discarded too
   always_ff @(posedge clk) begin
      if (flush_now) begin
         rr_robid <= alloc ? tail_id : f_decr_robid(tail_id);
      end else if (rr_state == RR_WALK) begin
         rr_robid <= f_decr_robid(rr_robid);
      end
   end

   assign rr_entry = entries[rr_robid.idx];

   always_comb begin
      restore.valid = (rr_state == RR_WALK) && (rr_entry.uinstr.dst_type == OP_REG);
      restore.gpr   = rr_entry.uinstr.dst_gpr;
      restore.prfid = rr_entry.pdst_old;
   end

   assign resume_fetch = (rr_state == RR_RESUME);

endmodule

`default_nettype wire

/* source/rat_map.sv */
`timescale 1ns/1ns
`default_nettype none

module rat_map (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      rename_en,
   input  rob_pkg::t_gpr_id          rename_gpr,
   input  rob_pkg::t_prf_id          rename_prf,
   output rob_pkg::t_prf_id          rename_old,
   input  rob_pkg::t_rat_restore_pkt restore,
   input  rob_pkg::t_gpr_id          src_gpr [rob_pkg::NUM_SOURCES-1:0],
   output rob_pkg::t_prf_id          src_prf [rob_pkg::NUM_SOURCES-1:0]
);
   import rob_pkg::*;

   t_prf_id map [NUM_GPRS-1:0];

   // Old mapping goes into the new entry's pdst_old
   assign rename_old = map[rename_gpr];

   for (genvar s = 0; s < NUM_SOURCES; s++) begin : g_lookup
      assign src_prf[s] = map[src_gpr[s]];
   end

   // Identity map out of reset, gpr i lives in prf i
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int g = 0; g < NUM_GPRS; g++) begin
            map[g] <= t_prf_id'(g);
         end
      end else if (restore.valid) begin
         map[restore.gpr] <= restore.prfid;
      end else if (rename_en) begin
         map[rename_gpr] <= rename_prf;
      end
   end

endmodule

`default_nettype wire

/* source/retire_top.sv */
`timescale 1ns/1ns
`default_nettype none

module retire_top (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       alloc,
   input  rob_pkg::t_uinstr           alloc_uinstr,
   input  rob_pkg::t_prf_id           alloc_pdst,
   input  rob_pkg::t_rob_complete_pkt ex_complete,
   input  rob_pkg::t_rob_complete_pkt mm_complete,
   input  rob_pkg::t_gpr_id           src_gpr     [rob_pkg::NUM_SOURCES-1:0],
   output rob_pkg::t_prf_id           src_prf     [rob_pkg::NUM_SOURCES-1:0],
   output logic                       src_pending [rob_pkg::NUM_SOURCES-1:0],
   output rob_pkg::t_rob_id           src_robid   [rob_pkg::NUM_SOURCES-1:0],
   output logic                       rob_ready,
   output rob_pkg::t_rob_id           next_robid,
   output rob_pkg::t_rob_id           oldest_robid,
   output rob_pkg::t_uinstr           retire_uinstr,
   output rob_pkg::t_rat_reclaim_pkt  reclaim,
   output rob_pkg::t_nuke_pkt         nuke,
   output logic                       resume_fetch
);
   import rob_pkg::*;

   logic             rename_en;
   t_prf_id          pdst_old;
   t_rat_restore_pkt restore;

   // Only register writers change the map
   assign rename_en = alloc && (alloc_uinstr.dst_type == OP_REG);

   rob i_rob (
      .clk           (clk),
      .reset         (reset),
      .alloc         (alloc),
      .alloc_uinstr  (alloc_uinstr),
      .pdst_old      (pdst_old),
      .ex_complete   (ex_complete),
      .mm_complete   (mm_complete),
      .src_gpr       (src_gpr),
      .src_pending   (src_pending),
      .src_robid     (src_robid),
      .rob_ready     (rob_ready),
      .next_robid    (next_robid),
      .oldest_robid  (oldest_robid),
      .retire_uinstr (retire_uinstr),
      .reclaim       (reclaim),
      .restore       (restore),
      .nuke          (nuke),
      .resume_fetch  (resume_fetch)
   );

   rat_map i_rat_map (
      .clk        (clk),
      .reset      (reset),
      .rename_en  (rename_en),
      .rename_gpr (alloc_uinstr.dst_gpr),
      .rename_prf (alloc_pdst),
      .rename_old (pdst_old),
      .restore    (restore),
      .src_gpr    (src_gpr),
      .src_prf    (src_prf)
   );

endmodule

`default_nettype wire

/* verif/tb_retire.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_retire;
   import rob_pkg::*;

   // Tests take about 160 cycles, the limit leaves a wide margin
   localparam int TIMEOUT_CYCLES = 400;
   localparam logic [31:0] SEED  = 32'h71d04063;

   typedef struct packed {
      t_rob_id robid;
      t_gpr_id gpr;
      t_prf_id pdst_old;
      logic    mispred;
   } t_model_ent;

   logic              clk;
   logic              reset;
   logic              alloc;
   t_uinstr           alloc_uinstr;
   t_prf_id           alloc_pdst;
   t_rob_complete_pkt ex_complete;
   t_rob_complete_pkt mm_complete;
   t_gpr_id           src_gpr     [NUM_SOURCES-1:0];
   t_prf_id           src_prf     [NUM_SOURCES-1:0];
   logic              src_pending [NUM_SOURCES-1:0];
   t_rob_id           src_robid   [NUM_SOURCES-1:0];
   logic              rob_ready;
   t_rob_id           next_robid;
   t_rob_id           oldest_robid;
   t_uinstr           retire_uinstr;
   t_rat_reclaim_pkt  reclaim;
   t_nuke_pkt         nuke;
   logic              resume_fetch;

   // Reference model, in-flight entries oldest first plus the speculative map
   t_model_ent model_q [$];
   t_model_ent restore_q [$];
   t_prf_id    model_map [NUM_GPRS];
   t_rob_id    model_tail;
   t_model_ent last_retired;
   t_nuke_type nuke_type_seen;
   int         cycle;
   int         retire_count;
   int         nuke_count;
   int         resume_count;
   int         restore_seen;
   int         nuke_cycle;
   int         resume_cycle;

   retire_top i_retire_top (
      .clk           (clk),
      .reset         (reset),
      .alloc         (alloc),
      .alloc_uinstr  (alloc_uinstr),
      .alloc_pdst    (alloc_pdst),
      .ex_complete   (ex_complete),
      .mm_complete   (mm_complete),
      .src_gpr       (src_gpr),
      .src_prf       (src_prf),
      .src_pending   (src_pending),
      .src_robid     (src_robid),
      .rob_ready     (rob_ready),
      .next_robid    (next_robid),
      .oldest_robid  (oldest_robid),
      .retire_uinstr (retire_uinstr),
      .reclaim       (reclaim),
      .nuke          (nuke),
      .resume_fetch  (resume_fetch)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle >= TIMEOUT_CYCLES) begin
         $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Checks failed");
         $fatal(1, "run stopped by timeout");
      end
   end

   task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         $display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
         $display("Checks failed");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic fail_now(input string why);
      $display("%s", why);
      $display("Checks failed");
      $fatal(1, "stopped at first failure");
   endtask

   // Retirement, nuke, walk and resume are checked as they happen
   always @(negedge clk) begin
      t_model_ent ent;
      if (!reset) begin
         if (reclaim.valid) begin
            if (model_q.size() == 0) fail_now("retirement with no entry in flight");
            ent = model_q.pop_front();
            check_eq(32'(oldest_robid), 32'(ent.robid), "retiring robid");
            check_eq(32'(retire_uinstr.dst_gpr), 32'(ent.gpr), "retire gpr");
            check_eq(32'(retire_uinstr.mispred), 32'(ent.mispred), "retire mispred");
            check_eq(32'(reclaim.prfid), 32'(ent.pdst_old), "reclaim prfid");
            last_retired = ent;
            retire_count++;
         end
         if (nuke.valid) begin
            if (!reclaim.valid) fail_now("nuke without a retiring entry");
            nuke_cycle     = cycle;
            nuke_type_seen = nuke.nuke_type;
            restore_seen   = 0;
            // Younger entries are discarded, restored youngest first
            restore_q = {};
            while (model_q.size() > 0) restore_q.push_back(model_q.pop_back());
            model_tail = t_rob_id'(last_retired.robid + 1'b1);
            nuke_count++;
         end
         if (i_retire_top.restore.valid) begin
            if (restore_q.size() == 0) fail_now("restore packet for an entry never discarded");
            ent = restore_q.pop_front();
            check_eq(32'(i_retire_top.restore.gpr), 32'(ent.gpr), "restore gpr");
            check_eq(32'(i_retire_top.restore.prfid), 32'(ent.pdst_old), "restore prfid");
            restore_seen++;
         end
         if (resume_fetch) begin
            if (restore_q.size() != 0) fail_now("resume_fetch before the walk finished");
            resume_cycle = cycle;
            resume_count++;
         end
      end
   end

   task automatic alloc_one(input t_gpr_id gpr, input logic mispred, output t_rob_id id);
      t_prf_id    pdst;
      t_model_ent ent;
      pdst = t_prf_id'($urandom % NUM_PRFS);
      @(posedge clk);
      alloc        <= 1'b1;
      alloc_uinstr <= '{dst_type: OP_REG, dst_gpr: gpr, mispred: mispred};
      alloc_pdst   <= pdst;
      @(negedge clk);
      check_eq(32'(rob_ready), 32'(1'b1), "rob_ready at allocation");
      check_eq(32'(next_robid), 32'(model_tail), "next_robid");
      ent = '{robid: model_tail, gpr: gpr, pdst_old: model_map[gpr], mispred: mispred};
      model_q.push_back(ent);
      model_map[gpr] = pdst;
      id = model_tail;
      model_tail = t_rob_id'(model_tail + 1'b1);
      @(posedge clk);
      alloc <= 1'b0;
   endtask

   task automatic complete_one(input t_rob_id id, input logic flush);
      @(posedge clk);
      ex_complete <= '{valid: 1'b1, robid: id, flush_needed: flush};
      @(posedge clk);
      ex_complete <= '0;
   endtask

   // Both result ports in one cycle
   task automatic complete_two(input t_rob_id id_a, input t_rob_id id_b);
      @(posedge clk);
      ex_complete <= '{valid: 1'b1, robid: id_a, flush_needed: 1'b0};
      mm_complete <= '{valid: 1'b1, robid: id_b, flush_needed: 1'b0};
      @(posedge clk);
      ex_complete <= '0;
      mm_complete <= '0;
   endtask

   task automatic wait_retired(input int n);
      wait (retire_count == n);
   endtask

   function automatic logic youngest_writer(input t_gpr_id g, output t_rob_id id);
      logic found;
      found = 1'b0;
      id    = '0;
      for (int i = model_q.size() - 1; i >= 0; i--) begin
         if (!found && model_q[i].gpr == g) begin
            found = 1'b1;
            id    = model_q[i].robid;
         end
      end
      return found;
   endfunction

   // Sweeps every gpr through both sources
   task automatic lookup_all();
      t_gpr_id g;
      t_rob_id id;
      logic    pend;
      for (int k = 0; k < NUM_GPRS; k++) begin
         @(posedge clk);
         src_gpr[0] <= t_gpr_id'(k);
         src_gpr[1] <= t_gpr_id'(NUM_GPRS - 1 - k);
         @(negedge clk);
         for (int s = 0; s < NUM_SOURCES; s++) begin
            g    = src_gpr[s];
            pend = youngest_writer(g, id);
            check_eq(32'(src_prf[s]), 32'(model_map[g]), "src_prf");
            check_eq(32'(src_pending[s]), 32'(pend), "src_pending");
            if (pend) check_eq(32'(src_robid[s]), 32'(id), "src_robid");
         end
      end
   endtask

   task automatic in_order_retire_test();
      t_rob_id ids [4];
      int      base;
      base = retire_count;
      for (int k = 0; k < 4; k++) alloc_one(t_gpr_id'($urandom % NUM_GPRS), 1'b0, ids[k]);
      complete_one(ids[2], 1'b0);
      complete_one(ids[0], 1'b0);
      wait_retired(base + 1);
      complete_two(ids[3], ids[1]);
      wait_retired(base + 4);
   endtask

   task automatic full_buffer_test();
      t_rob_id ids [RB_NUM_ENTS];
      t_rob_id exp_next;
      int      base;
      base = retire_count;
      for (int k = 0; k < RB_NUM_ENTS; k++) begin
         alloc_one(t_gpr_id'($urandom % NUM_GPRS), 1'b0, ids[k]);
      end
      @(negedge clk);
      exp_next = '{wrap: !ids[0].wrap, idx: ids[0].idx};
      check_eq(32'(rob_ready), 32'(1'b0), "rob_ready when full");
      check_eq(32'(oldest_robid), 32'(ids[0]), "oldest_robid when full");
      check_eq(32'(next_robid), 32'(exp_next), "next_robid when full");
      complete_one(ids[0], 1'b0);
      wait_retired(base + 1);
      @(negedge clk);
      check_eq(32'(rob_ready), 32'(1'b1), "rob_ready after one retirement");
      complete_two(ids[1], ids[2]);
      complete_two(ids[3], ids[4]);
      complete_two(ids[5], ids[6]);
      complete_one(ids[7], 1'b0);
      wait_retired(base + RB_NUM_ENTS);
   endtask

   task automatic source_lookup_test();
      t_rob_id ids [4];
      t_gpr_id g_a;
      t_gpr_id g_b;
      int      base;
      base = retire_count;
      g_a  = t_gpr_id'($urandom % NUM_GPRS);
      g_b  = t_gpr_id'(g_a + 1 + ($urandom % (NUM_GPRS - 1)));
      alloc_one(g_a, 1'b0, ids[0]);
      alloc_one(g_b, 1'b0, ids[1]);
      alloc_one(g_a, 1'b0, ids[2]);
      alloc_one(t_gpr_id'($urandom % NUM_GPRS), 1'b0, ids[3]);
      lookup_all();
      complete_two(ids[0], ids[1]);
      complete_two(ids[2], ids[3]);
      wait_retired(base + 4);
      lookup_all();
   endtask

   task automatic flush_restore_test();
      t_rob_id ids [6];
      t_prf_id snap [NUM_GPRS];
      int      base;
      int      n_nuke;
      int      n_resume;
      base = retire_count;
      for (int k = 0; k < 6; k++) begin
         alloc_one(t_gpr_id'($urandom % NUM_GPRS), k == 2, ids[k]);
         if (k == 2) snap = model_map;
      end
      complete_two(ids[0], ids[1]);
      wait_retired(base + 2);
      n_nuke   = nuke_count;
      n_resume = resume_count;
      complete_one(ids[2], 1'b1);
      wait (nuke_count == n_nuke + 1);
      check_eq(32'(nuke_type_seen), 32'(NUKE_BR_MISPRED), "nuke type");
      wait (resume_count == n_resume + 1);
      check_eq(32'(restore_seen), 32'd3, "restore packet count");
      check_eq(32'(resume_cycle - nuke_cycle), 32'(1 + RR_QUIESCE_CYCLES + 3), "recovery latency");
      @(negedge clk);
      check_eq(32'(next_robid), 32'(t_rob_id'(ids[2] + 1'b1)), "next_robid after flush");
      check_eq(32'(rob_ready), 32'(1'b1), "rob_ready after recovery");
      model_map = snap;
      lookup_all();
   endtask

   task automatic exception_flush_test();
      t_rob_id id;
      int      n_nuke;
      int      n_resume;
      alloc_one(t_gpr_id'($urandom % NUM_GPRS), 1'b0, id);
      n_nuke   = nuke_count;
      n_resume = resume_count;
      complete_one(id, 1'b1);
      wait (nuke_count == n_nuke + 1);
      check_eq(32'(nuke_type_seen), 32'(NUKE_EXCEPTION), "nuke type");
      wait (resume_count == n_resume + 1);
      check_eq(32'(restore_seen), 32'd0, "restore packet count");
      check_eq(32'(resume_cycle - nuke_cycle), 32'(1 + RR_QUIESCE_CYCLES), "recovery latency");
   endtask

   initial begin
      void'($urandom(SEED));
      reset        = 1'b1;
      alloc        = 1'b0;
      alloc_uinstr = '0;
      alloc_pdst   = '0;
      ex_complete  = '0;
      mm_complete  = '0;
      for (int s = 0; s < NUM_SOURCES; s++) src_gpr[s] = '0;
      for (int g = 0; g < NUM_GPRS; g++) model_map[g] = t_prf_id'(g);
      model_tail   = '0;
      cycle        = 0;
      retire_count = 0;
      nuke_count   = 0;
      resume_count = 0;
      restore_seen = 0;
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check_eq(32'(rob_ready), 32'(1'b1), "rob_ready after reset");
      check_eq(32'(next_robid), 32'(model_tail), "next_robid after reset");
      in_order_retire_test();
      full_buffer_test();
      source_lookup_test();
      flush_restore_test();
      exception_flush_test();
      $display("All checks passed");
      $finish;
   end

endmodule

`default_nettype wire

/* src.f */
source/rob_pkg.sv
source/rob_entry.sv
source/rob.sv
source/rat_map.sv
source/retire_top.sv
verif/tb_retire.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

if ! verilator --binary --timing -Wno-fatal --top-module tb_retire -f src.f -o sim_retire; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_retire > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Checks failed" sim.log; then
   echo "Simulation failed"
   exit 1
fi
if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi
echo "Simulation passed"
exit 0
